/* list.f */
logic/pll_types_pkg.sv
logic/cfg_pkg.sv
logic/phase_detector.sv
logic/pi_loop_filter.sv
logic/lock_detector.sv
logic/gain_config_port.sv
logic/adpll_core.sv
tests/tb_clock_gen.sv
tests/tb_adpll_core.sv

/* Bender.yml */
package:
  name: adpll_core

sources:
  - logic/pll_types_pkg.sv
  - logic/cfg_pkg.sv
  - logic/phase_detector.sv
  - logic/pi_loop_filter.sv
  - logic/lock_detector.sv
  - logic/gain_config_port.sv
  - logic/adpll_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_adpll_core.sv

/* tests/tb_adpll_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adpll_core
	import pll_types_pkg::*;
	import cfg_pkg::*;
();

	localparam int LOCK_COUNT    = 8;
	localparam int KP_RESET      = 1;
	localparam int KI_RESET      = 1;
	localparam int WAIT_LIMIT    = 20;
	localparam int PHASE_MASK    = (1 << PHASE_WIDTH_DEF) - 1;
	localparam int ERR_HI        = (1 << (ERROR_WIDTH_DEF - 1)) - 1;
	localparam int KI_INT_BITS   = KI_WIDTH_DEF - KI_FRAC_WIDTH_DEF;
	localparam int ACC_BITS      = ERROR_WIDTH_DEF + KI_INT_BITS + KI_FRAC_WIDTH_DEF + 2;
	localparam int ACC_HI        = (1 << (ACC_BITS - 1)) - 1;
	localparam int CC_HI         = (1 << (DCO_CC_WIDTH_DEF - 1)) - 1;

	logic                               gen_clk;
	logic                               reset;
	logic        [PHASE_WIDTH_DEF-1:0]  ref_phase;
	logic        [PHASE_WIDTH_DEF-1:0]  fb_phase;
	logic                               cfg_req;
	cfg_op_e                            cfg_op;
	logic        [7:0]                  cfg_data;
	logic                               cfg_ack;
	logic signed [DCO_CC_WIDTH_DEF-1:0] dco_cc;
	logic                               lock;

	// reference model state mirrors the pipeline registers
	int         err_m;
	int         acc_m;
	int         cc_m;
	int         run_m;
	int         kp_m;
	int         ki_m;
	int         win_m;
	int         p_t;
	bit         lock_m;
	bit         clr_m;
	bit         busy_m;
	logic [31:0] lfsr_state;
	int         err_cnt;
	int         test_cnt;
	int         test_start;

	tb_clock_gen u_clock_gen (
		.gen_clk_o (gen_clk),
		.reset_o   (reset)
	);

	adpll_core #(
		.KP          (KP_WIDTH_DEF'(KP_RESET)),
		.KI          (KI_WIDTH_DEF'(KI_RESET)),
		.DYNAMIC_VAL (1'b1),
		.LOCK_COUNT  (LOCK_COUNT)
	) dut (
		.gen_clk_i   (gen_clk),
		.reset_i     (reset),
		.ref_phase_i (ref_phase),
		.fb_phase_i  (fb_phase),
		.cfg_req_i   (cfg_req),
		.cfg_op_i    (cfg_op),
		.cfg_data_i  (cfg_data),
		.cfg_ack_o   (cfg_ack),
		.dco_cc_o    (dco_cc),
		.lock_o      (lock)
	);

	function automatic int clip(input int v, input int hi);
		if (v > hi)
			return hi;
		if (v < -hi - 1)
			return -hi - 1;
		return v;
	endfunction

	function automatic int to_signed(input int v, input int w);
		return (v >= (1 << (w - 1))) ? v - (1 << w) : v;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic abort_run(input string msg);
		$display("timeout at %0t ns: %s", $time, msg);
		$display("tests run: %0d, errors: %0d", test_cnt, err_cnt + 1);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic close_test(input string name);
		test_cnt++;
		$display("test %s finished with %0d errors", name, err_cnt - test_start);
		test_start = err_cnt;
	endtask

	task automatic drive_phase(input int r, input int f, input int cycles);
		repeat (cycles)
		begin
			@(posedge gen_clk);
			ref_phase <= PHASE_WIDTH_DEF'(r);
			fb_phase  <= PHASE_WIDTH_DEF'(f);
		end
	endtask

	// feedback trails a random reference phase by e
	task automatic drive_error(input int e, input int cycles);
		logic [31:0] base;
		draw_bits(PHASE_WIDTH_DEF, base);
		drive_phase(int'(base), (int'(base) - e) & PHASE_MASK, cycles);
	endtask

	task automatic cfg_write(input cfg_op_e op, input logic [7:0] data, input int hold);
		int n;
		@(posedge gen_clk);
		cfg_op   <= op;
		cfg_data <= data;
		cfg_req  <= 1'b1;
		n = 0;
		@(negedge gen_clk);
		while (!cfg_ack && n < WAIT_LIMIT)
		begin
			@(negedge gen_clk);
			n++;
		end
		if (!cfg_ack)
			abort_run("config port never raised ack");
		repeat (hold) @(posedge gen_clk);
		@(posedge gen_clk);
		cfg_req <= 1'b0;
		n = 0;
		@(negedge gen_clk);
		while (cfg_ack && n < WAIT_LIMIT)
		begin
			@(negedge gen_clk);
			n++;
		end
		if (cfg_ack)
			abort_run("config port kept ack high after req dropped");
	endtask

	always @(posedge gen_clk or posedge reset)
	begin
		if (reset)
		begin
			err_m  = 0;
			acc_m  = 0;
			cc_m   = 0;
			run_m  = 0;
			lock_m = 1'b0;
			clr_m  = 1'b0;
			busy_m = 1'b0;
			kp_m   = KP_RESET;
			ki_m   = KI_RESET;
			win_m  = 4;
		end
		else
		begin
			// filter and lock consume the error held before this edge
			p_t   = err_m * to_signed(kp_m, KP_WIDTH_DEF)
				* (1 << (KI_FRAC_WIDTH_DEF - KP_FRAC_WIDTH_DEF));
			acc_m = clr_m ? 0 : clip(acc_m + err_m * to_signed(ki_m, KI_WIDTH_DEF), ACC_HI);
			cc_m  = clip((p_t + acc_m) >>> KI_FRAC_WIDTH_DEF, CC_HI);
			if ((err_m < 0 ? -err_m : err_m) <= win_m)
				run_m = (run_m < LOCK_COUNT) ? run_m + 1 : run_m;
			else
				run_m = 0;
			lock_m = (run_m >= LOCK_COUNT);
			err_m  = to_signed((int'(ref_phase) - int'(fb_phase)) & PHASE_MASK, PHASE_WIDTH_DEF);
			err_m  = clip(err_m, ERR_HI);
			clr_m  = 1'b0;
			if (cfg_req && !busy_m)
			begin
				case (cfg_op)
					CFG_SET_KP:       kp_m  = int'(cfg_data[KP_WIDTH_DEF-1:0]);
					CFG_SET_KI:       ki_m  = int'(cfg_data[KI_WIDTH_DEF-1:0]);
					CFG_SET_LOCK_WIN: win_m = int'(cfg_data);
					default:          clr_m = 1'b1;
				endcase
			end
			busy_m = cfg_req;
		end
	end

	assert property (@(posedge gen_clk) (reset || $past(reset))
		|-> (dco_cc == '0 && !lock && !cfg_ack))
		else flag_error("outputs not zero during or right after reset");
	assert property (@(posedge gen_clk) disable iff (reset) dco_cc == cc_m)
		else flag_error($sformatf("dco_cc_o is %0d, model expects %0d",
			$sampled(dco_cc), $sampled(cc_m)));
	assert property (@(posedge gen_clk) disable iff (reset) lock == lock_m)
		else flag_error($sformatf("lock_o is %0b, model expects %0b",
			$sampled(lock), $sampled(lock_m)));
	assert property (@(posedge gen_clk) disable iff (reset) $rose(cfg_ack) |-> $past(cfg_req))
		else flag_error("ack rose without a request");
	assert property (@(posedge gen_clk) disable iff (reset) (cfg_ack && cfg_req) |=> cfg_ack)
		else flag_error("ack dropped while req was still high");
	assert property (@(posedge gen_clk) disable iff (reset) (cfg_ack && !cfg_req) |=> !cfg_ack)
		else flag_error("ack stayed high after req dropped");

	initial
	begin
		int n;
		logic [31:0] v;
		ref_phase  = '0;
		fb_phase   = '0;
		cfg_req    = 1'b0;
		cfg_op     = CFG_SET_KP;
		cfg_data   = '0;
		lfsr_state = 32'h1fea_a906;
		err_cnt    = 0;
		test_cnt   = 0;
		test_start = 0;
		n = 0;
		while (reset !== 1'b0 && n < WAIT_LIMIT)
		begin
			@(negedge gen_clk);
			n++;
		end
		if (reset !== 1'b0)
			abort_run("reset was never released");
		drive_phase(0, 0, 3);
		close_test("reset state");

		// kp written mid-stream and the second write holds req longer
		drive_error(20, 2);
		cfg_write(CFG_SET_KP, 8'h03, 0);
		drive_error(20, 3);
		cfg_write(CFG_SET_KP, 8'h06, 3);
		drive_error(-20, 3);
		close_test("handshake");

		cfg_write(CFG_SET_KI, 8'h00, 0);
		cfg_write(CFG_CLEAR_INT, 8'h00, 0);
		cfg_write(CFG_SET_KP, 8'h03, 1);
		repeat (40)
		begin
			draw_bits(8, v);
			drive_error(to_signed(int'(v[7:0]), 8), 1);
		end
		drive_error(0, 3);
		close_test("proportional path");

		cfg_write(CFG_SET_KP, 8'h00, 0);
		cfg_write(CFG_SET_KI, 8'h05, 0);
		cfg_write(CFG_CLEAR_INT, 8'h00, 0);
		drive_error(40, 50);
		drive_phase(400, 0, 10);
		drive_phase(0, 300, 40);
		drive_error(0, 2);
		cfg_write(CFG_CLEAR_INT, 8'h00, 0);
		drive_error(0, 3);
		close_test("integral path and saturation");

		cfg_write(CFG_SET_KP, 8'h02, 0);
		cfg_write(CFG_SET_KI, 8'h00, 0);
		cfg_write(CFG_CLEAR_INT, 8'h00, 0);
		drive_phase(3, 1020, 2);
		drive_phase(1018, 5, 2);
		drive_phase(1023, 0, 2);
		drive_phase(0, 1023, 2);
		drive_error(0, 3);
		close_test("phase wrap");

		cfg_write(CFG_SET_LOCK_WIN, 8'd10, 0);
		drive_error(30, 2);
		repeat (LOCK_COUNT + 3)
		begin
			draw_bits(5, v);
			drive_error(int'(v % 21) - 10, 1);
		end
		drive_error(11, 1);
		drive_error(-10, 1);
		// runs one short of the count
		repeat (4)
		begin
			drive_error(5, LOCK_COUNT - 1);
			drive_error(-40, 1);
		end
		drive_error(0, 3);
		close_test("lock");

		$display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
)
(
	output logic gen_clk_o,
	output logic reset_o
);

	initial
	begin
		gen_clk_o = 1'b0;
		forever #(PERIOD_NS / 2) gen_clk_o = ~gen_clk_o;
	end

	// reset rises just after time zero and is released on a rising edge
	initial
	begin
		reset_o = 1'b0;
		#1;
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge gen_clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* logic/adpll_core.sv */
`timescale 1ns/1ps
`default_nettype none

module adpll_core
	import pll_types_pkg::*;
	import cfg_pkg::*;
#(
	parameter int                  PHASE_WIDTH   = PHASE_WIDTH_DEF,
	parameter int                  ERROR_WIDTH   = ERROR_WIDTH_DEF,
	parameter int                  DCO_CC_WIDTH  = DCO_CC_WIDTH_DEF,
	parameter int                  KP_WIDTH      = KP_WIDTH_DEF,
	parameter int                  KP_FRAC_WIDTH = KP_FRAC_WIDTH_DEF,
	parameter int                  KI_WIDTH      = KI_WIDTH_DEF,
	parameter int                  KI_FRAC_WIDTH = KI_FRAC_WIDTH_DEF,
	parameter logic [KP_WIDTH-1:0] KP            = KP_WIDTH'(1),
	parameter logic [KI_WIDTH-1:0] KI            = KI_WIDTH'(1),
	parameter bit                  DYNAMIC_VAL   = 1'b0,
	parameter int                  LOCK_COUNT    = 8
)
(
	input  wire                            gen_clk_i,
	input  wire                            reset_i,
	input  wire         [PHASE_WIDTH-1:0]  ref_phase_i,
	input  wire         [PHASE_WIDTH-1:0]  fb_phase_i,
	input  wire                            cfg_req_i,
	input  cfg_op_e                        cfg_op_i,
	input  wire         [7:0]              cfg_data_i,
	output logic                           cfg_ack_o,
	output logic signed [DCO_CC_WIDTH-1:0] dco_cc_o,
	output logic                           lock_o
);

	logic signed [ERROR_WIDTH-1:0] error_w;
	logic        [KP_WIDTH-1:0]    kp_w;
	logic        [KI_WIDTH-1:0]    ki_w;
	logic        [7:0]             lock_win_w;
	logic                          int_clear_w;

	phase_detector #(
		.PHASE_WIDTH (PHASE_WIDTH),
		.ERROR_WIDTH (ERROR_WIDTH)
	) u_phase_detector (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.ref_phase_i (ref_phase_i),
		.fb_phase_i  (fb_phase_i),
		.error_o     (error_w)
	);

	pi_loop_filter #(
		.ERROR_WIDTH   (ERROR_WIDTH),
		.DCO_CC_WIDTH  (DCO_CC_WIDTH),
		.KP_WIDTH      (KP_WIDTH),
		.KP_FRAC_WIDTH (KP_FRAC_WIDTH),
		.KI_WIDTH      (KI_WIDTH),
		.KI_FRAC_WIDTH (KI_FRAC_WIDTH),
		.KP            (KP),
		.KI            (KI),
		.DYNAMIC_VAL   (DYNAMIC_VAL)
	) u_pi_loop_filter (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.error_i     (error_w),
		.kp_i        (kp_w),
		.ki_i        (ki_w),
		.int_clear_i (int_clear_w),
		.dco_cc_o    (dco_cc_o)
	);

	// lock watch runs in parallel with the filter
	lock_detector #(
		.ERROR_WIDTH (ERROR_WIDTH),
		.LOCK_COUNT  (LOCK_COUNT)
	) u_lock_detector (
		.gen_clk_i  (gen_clk_i),
		.reset_i    (reset_i),
		.error_i    (error_w),
		.lock_win_i (lock_win_w),
		.lock_o     (lock_o)
	);

	gain_config_port #(
		.KP_WIDTH (KP_WIDTH),
		.KI_WIDTH (KI_WIDTH),
		.KP       (KP),
		.KI       (KI)
	) u_gain_config_port (
		.gen_clk_i   (gen_clk_i),
		.reset_i     (reset_i),
		.cfg_req_i   (cfg_req_i),
		.cfg_op_i    (cfg_op_i),
		.cfg_data_i  (cfg_data_i),
		.cfg_ack_o   (cfg_ack_o),
		.kp_o        (kp_w),
		.ki_o        (ki_w),
		.lock_win_o  (lock_win_w),
		.int_clear_o (int_clear_w)
	);

endmodule

`default_nettype wire

/* logic/gain_config_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gain_config_port
	import cfg_pkg::*;
#(
	parameter int                  KP_WIDTH = 3,
	parameter int                  KI_WIDTH = 4,
	parameter logic [KP_WIDTH-1:0] KP       = KP_WIDTH'(1),
	parameter logic [KI_WIDTH-1:0] KI       = KI_WIDTH'(1)
)
(
	input  wire                 gen_clk_i,
	input  wire                 reset_i,
	input  wire                 cfg_req_i,
	input  cfg_op_e             cfg_op_i,
	input  wire  [7:0]          cfg_data_i,
	output logic                cfg_ack_o,
	output logic [KP_WIDTH-1:0] kp_o,
	output logic [KI_WIDTH-1:0] ki_o,
	output logic [7:0]          lock_win_o,
	output logic                int_clear_o
);

	localparam logic [7:0] LOCK_WIN_RESET = 8'd4;

	hs_state_e             state_r;
	logic [KP_WIDTH-1:0]   kp_r;
	logic [KI_WIDTH-1:0]   ki_r;
	logic [7:0]            lock_win_r;
	logic                  int_clear_r;

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			state_r     <= IDLE;
			kp_r        <= KP;
			ki_r        <= KI;
			lock_win_r  <= LOCK_WIN_RESET;
			int_clear_r <= 1'b0;
		end
		else
		begin
			// clear is a single-cycle pulse
			int_clear_r <= 1'b0;
			case (state_r)
				IDLE:
				begin
					if (cfg_req_i)
					begin
						state_r <= ACK;
						// op and data are stable while req is high
						case (cfg_op_i)
							CFG_SET_KP:       kp_r        <= cfg_data_i[KP_WIDTH-1:0];
							CFG_SET_KI:       ki_r        <= cfg_data_i[KI_WIDTH-1:0];
							CFG_SET_LOCK_WIN: lock_win_r  <= cfg_data_i;
							default:          int_clear_r <= 1'b1;
						endcase
					end
				end
				ACK:
				begin
					if (cfg_req_i)
						state_r <= WAIT_DROP;
					else
						state_r <= IDLE;
				end
				WAIT_DROP:
				begin
					if (!cfg_req_i)
						state_r <= IDLE;
				end
				default:
				begin
					state_r <= IDLE;
				end
			endcase
		end
	end

	// ack follows the registered state
	assign cfg_ack_o   = (state_r != IDLE);
	assign kp_o        = kp_r;
	assign ki_o        = ki_r;
	assign lock_win_o  = lock_win_r;
	assign int_clear_o = int_clear_r;

endmodule

`default_nettype wire

/* logic/lock_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module lock_detector #(
	parameter int ERROR_WIDTH = 8,
	parameter int LOCK_COUNT  = 8
)
(
	input  wire                          gen_clk_i,
	input  wire                          reset_i,
	input  wire signed [ERROR_WIDTH-1:0] error_i,
	input  wire        [7:0]             lock_win_i,
	output logic                         lock_o
);

	localparam int CNT_WIDTH = $clog2(LOCK_COUNT + 1);

	logic [ERROR_WIDTH-1:0] mag_c;
	logic                   in_win_c;
	logic [CNT_WIDTH-1:0]   run_cnt_r;
	logic                   lock_r;

	// unsigned magnitude, the most negative error still fits
	assign mag_c    = error_i[ERROR_WIDTH-1] ? (~error_i + 1'b1) : error_i;
	assign in_win_c = (mag_c <= lock_win_i);

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			run_cnt_r <= '0;
			lock_r    <= 1'b0;
		end
		else if (in_win_c)
		begin
			// run counter holds once the full count is reached
			if (run_cnt_r < CNT_WIDTH'(LOCK_COUNT))
				run_cnt_r <= run_cnt_r + 1'b1;
			// this sample completes the run
			if (run_cnt_r >= CNT_WIDTH'(LOCK_COUNT - 1))
				lock_r <= 1'b1;
		end
		else
		begin
			run_cnt_r <= '0;
			lock_r    <= 1'b0;
		end
	end

	assign lock_o = lock_r;

endmodule

`default_nettype wire

/* logic/pi_loop_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_loop_filter
	import pll_types_pkg::*;
#(
	parameter int                  ERROR_WIDTH   = 8,
	parameter int                  DCO_CC_WIDTH  = 9,
	parameter int                  KP_WIDTH      = 3,
	parameter int                  KP_FRAC_WIDTH = 1,
	parameter int                  KI_WIDTH      = 4,
	parameter int                  KI_FRAC_WIDTH = 3,
	parameter logic [KP_WIDTH-1:0] KP            = KP_WIDTH'(1),
	parameter logic [KI_WIDTH-1:0] KI            = KI_WIDTH'(1),
	parameter bit                  DYNAMIC_VAL   = 1'b0
)
(
	input  wire                           gen_clk_i,
	input  wire                           reset_i,
	input  wire signed  [ERROR_WIDTH-1:0] error_i,
	input  wire         [KP_WIDTH-1:0]    kp_i,
	input  wire         [KI_WIDTH-1:0]    ki_i,
	input  wire                           int_clear_i,
	output logic signed [DCO_CC_WIDTH-1:0] dco_cc_o
);

	// both products end up with KI_FRAC_WIDTH fractional bits
	localparam int KP_PROD_WIDTH = ERROR_WIDTH + KP_WIDTH;
	localparam int KI_PROD_WIDTH = ERROR_WIDTH + KI_WIDTH;
	localparam int P_WIDTH       = KP_PROD_WIDTH + KI_FRAC_WIDTH - KP_FRAC_WIDTH;
	localparam int ACC_WIDTH     = ERROR_WIDTH + KI_WIDTH + 2;
	localparam int SUM_WIDTH     = ((P_WIDTH > ACC_WIDTH) ? P_WIDTH : ACC_WIDTH) + 1;

	localparam logic signed [ACC_WIDTH-1:0] ACC_MAX = {1'b0, {(ACC_WIDTH-1){1'b1}}};
	localparam logic signed [ACC_WIDTH-1:0] ACC_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};
	localparam logic signed [DCO_CC_WIDTH-1:0] CC_MAX = {1'b0, {(DCO_CC_WIDTH-1){1'b1}}};
	localparam logic signed [DCO_CC_WIDTH-1:0] CC_MIN = {1'b1, {(DCO_CC_WIDTH-1){1'b0}}};

	logic signed [KP_WIDTH-1:0]      kp_sel_c;
	logic signed [KI_WIDTH-1:0]      ki_sel_c;
	logic signed [KP_PROD_WIDTH-1:0] kp_prod_c;
	logic signed [KI_PROD_WIDTH-1:0] ki_prod_c;
	logic signed [P_WIDTH-1:0]       p_term_c;
	logic signed [ACC_WIDTH:0]       acc_sum_c;
	sat_mode_e                       acc_sat_c;
	logic signed [ACC_WIDTH-1:0]     acc_next_c;
	logic signed [ACC_WIDTH-1:0]     acc_r;
	logic signed [SUM_WIDTH-1:0]     sum_c;
	logic signed [SUM_WIDTH-1:0]     shift_c;
	sat_mode_e                       cc_sat_c;
	logic signed [DCO_CC_WIDTH-1:0]  cc_c;
	logic signed [DCO_CC_WIDTH-1:0]  cc_r;

	// gains are two's complement fixed point
	assign kp_sel_c = DYNAMIC_VAL ? kp_i : KP;
	assign ki_sel_c = DYNAMIC_VAL ? ki_i : KI;

	assign kp_prod_c = error_i * kp_sel_c;
	assign ki_prod_c = error_i * ki_sel_c;

	// realign kp product to the ki fraction
	assign p_term_c = kp_prod_c <<< (KI_FRAC_WIDTH - KP_FRAC_WIDTH);

	assign acc_sum_c = acc_r + ki_prod_c;

	always_comb
	begin
		if (acc_sum_c > ACC_MAX)
			acc_sat_c = SAT_HIGH;
		else if (acc_sum_c < ACC_MIN)
			acc_sat_c = SAT_LOW;
		else
			acc_sat_c = SAT_NONE;
	end

	always_comb
	begin
		case (acc_sat_c)
			SAT_HIGH: acc_next_c = ACC_MAX;
			SAT_LOW:  acc_next_c = ACC_MIN;
			default:  acc_next_c = acc_sum_c[ACC_WIDTH-1:0];
		endcase
		// clear drops the integral term from this update too
		if (int_clear_i)
			acc_next_c = '0;
	end

	// current sample already sits in acc_next_c
	assign sum_c   = p_term_c + acc_next_c;
	assign shift_c = sum_c >>> KI_FRAC_WIDTH;

	always_comb
	begin
		if (shift_c > CC_MAX)
			cc_sat_c = SAT_HIGH;
		else if (shift_c < CC_MIN)
			cc_sat_c = SAT_LOW;
		else
			cc_sat_c = SAT_NONE;
	end

	always_comb
	begin
		case (cc_sat_c)
			SAT_HIGH: cc_c = CC_MAX;
			SAT_LOW:  cc_c = CC_MIN;
			default:  cc_c = shift_c[DCO_CC_WIDTH-1:0];
		endcase
	end

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			acc_r <= '0;
			cc_r  <= '0;
		end
		else
		begin
			acc_r <= acc_next_c;
			cc_r  <= cc_c;
		end
	end

	assign dco_cc_o = cc_r;

endmodule

`default_nettype wire

/* logic/phase_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_detector
	import pll_types_pkg::*;
#(
	parameter int PHASE_WIDTH = 10,
	parameter int ERROR_WIDTH = 8
)
(
	input  wire                          gen_clk_i,
	input  wire                          reset_i,
	input  wire        [PHASE_WIDTH-1:0] ref_phase_i,
	input  wire        [PHASE_WIDTH-1:0] fb_phase_i,
	output logic signed [ERROR_WIDTH-1:0] error_o
);

	localparam logic signed [ERROR_WIDTH-1:0] ERR_MAX = {1'b0, {(ERROR_WIDTH-1){1'b1}}};
	localparam logic signed [ERROR_WIDTH-1:0] ERR_MIN = {1'b1, {(ERROR_WIDTH-1){1'b0}}};

	logic signed [PHASE_WIDTH-1:0] diff_c;
	sat_mode_e                     sat_c;
	logic signed [ERROR_WIDTH-1:0] error_c;
	logic signed [ERROR_WIDTH-1:0] error_r;

	// difference wraps modulo 2**PHASE_WIDTH, bits then read as signed
	assign diff_c = ref_phase_i - fb_phase_i;

	always_comb
	begin
		if (diff_c > ERR_MAX)
			sat_c = SAT_HIGH;
		else if (diff_c < ERR_MIN)
			sat_c = SAT_LOW;
		else
			sat_c = SAT_NONE;
	end

	always_comb
	begin
		case (sat_c)
			SAT_HIGH: error_c = ERR_MAX;
			SAT_LOW:  error_c = ERR_MIN;
			default:  error_c = diff_c[ERROR_WIDTH-1:0];
		endcase
	end

	always_ff @(posedge gen_clk_i or posedge reset_i)
	begin
		if (reset_i)
			error_r <= '0;
		else
			error_r <= error_c;
	end

	assign error_o = error_r;

endmodule

`default_nettype wire

/* logic/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

	// operations on the gain configuration port
	typedef enum logic [1:0]
	{
		CFG_SET_KP       = 2'd0,
		CFG_SET_KI       = 2'd1,
		CFG_SET_LOCK_WIN = 2'd2,
		CFG_CLEAR_INT    = 2'd3
	} cfg_op_e;

	// four-phase req/ack states
	typedef enum logic [1:0]
	{
		IDLE      = 2'd0,
		ACK       = 2'd1,
		WAIT_DROP = 2'd2
	} hs_state_e;

endpackage

`default_nettype wire

/* logic/pll_types_pkg.sv */
`default_nettype none

package pll_types_pkg;

	// phase words from the TDC
	localparam int PHASE_WIDTH_DEF = 10;

	// signed phase error after the detector
	localparam int ERROR_WIDTH_DEF = 8;

	// signed DCO control code
	localparam int DCO_CC_WIDTH_DEF = 9;

	// proportional gain, signed fixed point
	localparam int KP_WIDTH_DEF = 3;
	localparam int KP_FRAC_WIDTH_DEF = 1;

	// integral gain, signed fixed point
	localparam int KI_WIDTH_DEF = 4;
	localparam int KI_FRAC_WIDTH_DEF = 3;

	// clip status of a saturating stage
	typedef enum logic [1:0]
	{
		SAT_NONE = 2'd0,
		SAT_HIGH = 2'd1,
		SAT_LOW  = 2'd2
	} sat_mode_e;

endpackage

`default_nettype wire
